//--- source/wb_pkg.sv
//------------------------------------------------
// Writeback stage shared definitions
// Data width, functional unit one-hot positions,
// micro-op codes and layout, trap cause codes
//------------------------------------------------
`default_nettype none

package wb_pkg;

    localparam int XLEN = 32;               // Data and address width

    // Functional unit select, one bit per unit
    typedef logic [3:0] fu_t;

    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;

    // Control flow micro-op codes
    localparam logic [4:0] CFU_JALI   = 5'b00010; // Direct jump and link
    localparam logic [4:0] CFU_JALR   = 5'b00011; // Indirect jump and link
    localparam logic [4:0] CFU_TAKEN  = 5'b00100; // Conditional branch, taken
    localparam logic [4:0] CFU_EBREAK = 5'b01001;
    localparam logic [4:0] CFU_ECALL  = 5'b01010;

    // LSU access sizes
    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    //------------------------------------------------
    // Trap causes, mcause encoding
    typedef logic [5:0] cause_t;

    localparam cause_t TRAP_BREAKPT  = 6'd3;
    localparam cause_t TRAP_LDACCESS = 6'd5;
    localparam cause_t TRAP_STACCESS = 6'd7;
    localparam cause_t TRAP_ECALLM   = 6'd11;

    //------------------------------------------------
    // Micro-op word, read per unit
    typedef struct packed {
        logic       is_signed;              // Sign-extend the loaded value
        logic [1:0] size;                   // LSU_BYTE / LSU_HALF / LSU_WORD
        logic       store;
        logic       load;
    } lsu_uop_t;

    typedef union packed {
        lsu_uop_t   lsu;                    // Load/store view
        logic [4:0] cfu;                    // Control flow code
    } wb_uop_t;

endpackage

`default_nettype wire

//--- source/wb_control_flow.sv
//------------------------------------------------
// Writeback control flow unit
// Holds the stage PC, raises branch, jump and
// trap redirects, and picks the trap cause
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module wb_control_flow #(
    parameter logic [wb_pkg::XLEN-1:0] PC_RESET = 32'h8000_0000 // PC after reset
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::fu_t             s4_fu,          // Functional unit one-hot
    input  wb_pkg::wb_uop_t         s4_uop,
    input  logic [wb_pkg::XLEN-1:0] s4_opr_a,       // Jump target or trap cause
    input  logic                    s4_trap,        // Trap flagged upstream
    input  logic [1:0]              s4_size,        // Instr size in halfwords
    input  logic [wb_pkg::XLEN-1:0] csr_mtvec,      // Trap vector
    input  logic                    cf_ack,
    input  logic                    pipe_progress,
    input  logic                    lsu_trap,       // Data bus error
    input  logic                    lsu_load,
    input  logic                    lsu_store,
    output logic                    cf_req,
    output logic [wb_pkg::XLEN-1:0] cf_target,
    output logic                    cfu_busy,       // Waiting on cf_ack
    output logic                    cfu_link,       // Jump writes link reg
    output logic [wb_pkg::XLEN-1:0] link_wdata,     // Next sequential PC
    output logic                    trap_cpu,
    output wb_pkg::cause_t          trap_cause,
    output logic [wb_pkg::XLEN-1:0] trap_pc
);

    logic [wb_pkg::XLEN-1:0] s4_pc;         // PC of the instr in this stage
    logic                    fu_cfu;
    logic                    cfu_taken;     // Branch taken or any jump
    logic                    cfu_ebreak;
    logic                    cfu_ecall;
    logic                    cf_change;     // Redirect wanted by this instr
    logic                    cf_done;       // Redirect acked, stage still held
    logic                    cf_fire;       // Redirect accepted this cycle

    //------------------------------------------------
    // Program counter

    assign link_wdata = s4_pc + {{(wb_pkg::XLEN-3){1'b0}}, s4_size, 1'b0};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_pc <= PC_RESET;
        end else if (cf_fire) begin
            s4_pc <= cf_target;             // Redirect wins over step
        end else if (pipe_progress && !cf_done) begin
            s4_pc <= link_wdata;            // Already redirected if done
        end
    end

    assign trap_pc = s4_pc;

    //------------------------------------------------
    // Micro-op decode

    assign fu_cfu     = s4_fu[wb_pkg::FU_CFU];
    assign cfu_link   = fu_cfu && (s4_uop.cfu == wb_pkg::CFU_JALI ||
                                   s4_uop.cfu == wb_pkg::CFU_JALR);
    assign cfu_taken  = cfu_link || (fu_cfu && s4_uop.cfu == wb_pkg::CFU_TAKEN);
    assign cfu_ebreak = fu_cfu && s4_uop.cfu == wb_pkg::CFU_EBREAK;
    assign cfu_ecall  = fu_cfu && s4_uop.cfu == wb_pkg::CFU_ECALL;

    // Any trap source, instr or bus
    assign trap_cpu = cfu_ebreak || cfu_ecall || s4_trap || lsu_trap;

    //------------------------------------------------
    // Redirect handshake

    assign cf_change = cfu_taken || trap_cpu;
    assign cf_req    = cf_change && !cf_done;   // One request per instr
    assign cf_fire   = cf_req && cf_ack;
    assign cfu_busy  = cf_req && !cf_ack;
    assign cf_target = trap_cpu ? csr_mtvec : s4_opr_a;

    // Set on ack, cleared once the instr leaves the stage
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else begin
            cf_done <= !pipe_progress && (cf_done || cf_fire);
        end
    end

    // Cause priority, bus errors first
    assign trap_cause = (lsu_trap && lsu_load)  ? wb_pkg::TRAP_LDACCESS :
                        (lsu_trap && lsu_store) ? wb_pkg::TRAP_STACCESS :
                        cfu_ebreak              ? wb_pkg::TRAP_BREAKPT  :
                        cfu_ecall               ? wb_pkg::TRAP_ECALLM   :
                                                  s4_opr_a[5:0];       // Upstream code

endmodule

`default_nettype wire

//--- source/wb_load_unit.sv
//------------------------------------------------
// Writeback load unit
// Takes the data memory response, aligns and
// sign-extends load data, flags bus errors
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module wb_load_unit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::fu_t             s4_fu,
    input  wb_pkg::wb_uop_t         s4_uop,
    input  logic [wb_pkg::XLEN-1:0] s4_opr_a,       // Byte strobe in [3:0]
    input  logic [wb_pkg::XLEN-1:0] s4_opr_b,       // Access address
    input  logic                    pipe_progress,
    input  logic                    dmem_recv,
    input  logic                    dmem_error,
    input  logic [wb_pkg::XLEN-1:0] dmem_rdata,
    output logic                    dmem_ack,       // Ready for a response
    output logic                    lsu_busy,
    output logic                    lsu_load,
    output logic                    lsu_store,
    output logic                    lsu_gpr_wen,    // Load data valid for one cycle
    output logic [wb_pkg::XLEN-1:0] lsu_rdata,
    output logic                    lsu_trap        // Bus error on this access
);

    logic        fu_lsu;
    logic        rsp_seen;      // Response already taken
    logic        rsp_take;      // Response taken this cycle
    logic        err_seen;      // Error response taken earlier
    logic        sz_byte;
    logic        sz_half;
    logic        sz_word;
    logic [3:0]  strb;
    logic [1:0]  addr_lo;
    logic [7:0]  rd_b0;
    logic [7:0]  rd_b1;
    logic [15:0] rd_h1;

    //------------------------------------------------
    // Decode
    assign fu_lsu    = s4_fu[wb_pkg::FU_LSU];
    assign lsu_load  = fu_lsu && s4_uop.lsu.load;
    assign lsu_store = fu_lsu && s4_uop.lsu.store;
    assign sz_byte   = s4_uop.lsu.size == wb_pkg::LSU_BYTE;
    assign sz_half   = s4_uop.lsu.size == wb_pkg::LSU_HALF;
    assign sz_word   = s4_uop.lsu.size == wb_pkg::LSU_WORD;
    assign strb      = s4_opr_a[3:0];
    assign addr_lo   = s4_opr_b[1:0];

    //------------------------------------------------
    // Response tracking
    assign dmem_ack    = (lsu_load || lsu_store) && !rsp_seen;
    assign rsp_take    = dmem_recv && dmem_ack;
    assign lsu_busy    = (lsu_load || lsu_store) && !(rsp_seen || rsp_take);
    assign lsu_gpr_wen = rsp_take && lsu_load && !dmem_error;
    assign lsu_trap    = (rsp_take && dmem_error) || err_seen; // Held until redirect

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
            err_seen <= 1'b0;
        end else begin
            rsp_seen <= !pipe_progress && (rsp_seen || rsp_take);
            err_seen <= !pipe_progress && (err_seen || (rsp_take && dmem_error));
        end
    end

    //------------------------------------------------
    // Result built one byte at a time
    always_comb begin
        rd_b0 = 8'h00;
        if (strb[0]) rd_b0 = dmem_rdata[7:0];          // Lane 0 in use
        else if (sz_half) rd_b0 = dmem_rdata[23:16];   // Upper half
        else if (sz_byte) rd_b0 = dmem_rdata[{addr_lo, 3'b000} +: 8];

        rd_b1 = 8'h00;
        if (sz_word) rd_b1 = dmem_rdata[15:8];
        else if (sz_half) rd_b1 = addr_lo[1] ? dmem_rdata[31:24] : dmem_rdata[15:8];
        else if (sz_byte && s4_uop.lsu.is_signed) rd_b1 = {8{rd_b0[7]}};

        rd_h1 = 16'h0000;
        if (sz_word) rd_h1 = dmem_rdata[31:16];
        else if ((sz_byte || sz_half) && s4_uop.lsu.is_signed) rd_h1 = {16{rd_b1[7]}};
    end

    assign lsu_rdata = {rd_h1, rd_b1, rd_b0};

endmodule

`default_nettype wire

//--- source/wb_retire.sv
//------------------------------------------------
// Writeback retire logic
// Stage stall and progress, GPR write select
// and forwarding to earlier stages
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module wb_retire (
    input  logic                    s4_valid,
    input  wb_pkg::fu_t             s4_fu,
    input  logic [4:0]              s4_rd,
    input  logic [wb_pkg::XLEN-1:0] s4_opr_a,       // ALU/MUL result
    input  logic                    s4_trap,
    input  logic                    cfu_busy,
    input  logic                    cfu_link,
    input  logic [wb_pkg::XLEN-1:0] link_wdata,
    input  logic                    lsu_busy,
    input  logic                    lsu_gpr_wen,
    input  logic [wb_pkg::XLEN-1:0] lsu_rdata,
    input  logic                    cf_req,
    input  logic                    trap_cpu,
    output logic                    s4_busy,
    output logic                    pipe_progress,  // Instr retires this cycle
    output logic                    gpr_wen,
    output logic [4:0]              gpr_rd,
    output logic [wb_pkg::XLEN-1:0] gpr_wdata,
    output logic [4:0]              fwd_s4_rd,
    output logic [wb_pkg::XLEN-1:0] fwd_s4_wdata,
    output logic                    fwd_s4_load,
    output logic                    hold_lsu_req    // Stop new memory requests
);

    logic fu_alu;
    logic fu_mul;
    logic fu_lsu;
    logic simple_wen;           // ALU or MUL result
    logic link_wen;             // Jump link, written as it retires

    assign fu_alu = s4_fu[wb_pkg::FU_ALU];
    assign fu_mul = s4_fu[wb_pkg::FU_MUL];
    assign fu_lsu = s4_fu[wb_pkg::FU_LSU];

    // Stall while any unit still waits
    assign s4_busy       = cfu_busy || lsu_busy;
    assign pipe_progress = s4_valid && !s4_busy;

    //------------------------------------------------
    // GPR writeback
    assign simple_wen = s4_valid && (fu_alu || fu_mul);
    assign link_wen   = cfu_link && pipe_progress;
    assign gpr_wen    = !s4_trap && (simple_wen || lsu_gpr_wen || link_wen);
    assign gpr_rd     = s4_rd;
    assign gpr_wdata  = fu_lsu   ? lsu_rdata  :
                        cfu_link ? link_wdata :
                                   s4_opr_a;

    // Forwarding, load data not ready until response
    assign fwd_s4_rd    = s4_rd;
    assign fwd_s4_wdata = gpr_wdata;
    assign fwd_s4_load  = fu_lsu;

    assign hold_lsu_req = cf_req || trap_cpu || lsu_busy;

endmodule

`default_nettype wire

//--- source/wb_top.sv
//------------------------------------------------
// Writeback stage top level
// Connects control flow, load and retire units
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module wb_top #(
    parameter logic [wb_pkg::XLEN-1:0] PC_RESET = 32'h8000_0000
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic [4:0]              s4_rd,
    input  logic [wb_pkg::XLEN-1:0] s4_opr_a,
    input  logic [wb_pkg::XLEN-1:0] s4_opr_b,
    input  wb_pkg::wb_uop_t         s4_uop,
    input  wb_pkg::fu_t             s4_fu,
    input  logic                    s4_trap,
    input  logic [1:0]              s4_size,
    input  logic                    s4_valid,
    output logic                    s4_busy,
    output logic [4:0]              fwd_s4_rd,
    output logic [wb_pkg::XLEN-1:0] fwd_s4_wdata,
    output logic                    fwd_s4_load,
    output logic                    gpr_wen,
    output logic [4:0]              gpr_rd,
    output logic [wb_pkg::XLEN-1:0] gpr_wdata,
    output logic                    trap_cpu,
    output wb_pkg::cause_t          trap_cause,
    output logic [wb_pkg::XLEN-1:0] trap_pc,
    input  logic [wb_pkg::XLEN-1:0] csr_mtvec,
    output logic                    cf_req,
    output logic [wb_pkg::XLEN-1:0] cf_target,
    input  logic                    cf_ack,
    output logic                    hold_lsu_req,
    input  logic                    dmem_recv,
    output logic                    dmem_ack,
    input  logic                    dmem_error,
    input  logic [wb_pkg::XLEN-1:0] dmem_rdata
);

    // Unit to unit wires
    logic                    pipe_progress;
    logic                    cfu_busy;
    logic                    cfu_link;
    logic [wb_pkg::XLEN-1:0] link_wdata;
    logic                    lsu_busy;
    logic                    lsu_load;
    logic                    lsu_store;
    logic                    lsu_gpr_wen;
    logic [wb_pkg::XLEN-1:0] lsu_rdata;
    logic                    lsu_trap;

    wb_control_flow #(
        .PC_RESET (PC_RESET)
    ) u_control_flow (
        .g_clk, .g_resetn, .s4_fu, .s4_uop, .s4_opr_a, .s4_trap, .s4_size,
        .csr_mtvec, .cf_ack, .pipe_progress, .lsu_trap, .lsu_load, .lsu_store,
        .cf_req, .cf_target, .cfu_busy, .cfu_link, .link_wdata,
        .trap_cpu, .trap_cause, .trap_pc
    );

    wb_load_unit u_load_unit (
        .g_clk, .g_resetn, .s4_fu, .s4_uop, .s4_opr_a, .s4_opr_b,
        .pipe_progress, .dmem_recv, .dmem_error, .dmem_rdata,
        .dmem_ack, .lsu_busy, .lsu_load, .lsu_store, .lsu_gpr_wen,
        .lsu_rdata, .lsu_trap
    );

    wb_retire u_retire (
        .s4_valid, .s4_fu, .s4_rd, .s4_opr_a, .s4_trap,
        .cfu_busy, .cfu_link, .link_wdata,
        .lsu_busy, .lsu_gpr_wen, .lsu_rdata, .cf_req, .trap_cpu,
        .s4_busy, .pipe_progress, .gpr_wen, .gpr_rd, .gpr_wdata,
        .fwd_s4_rd, .fwd_s4_wdata, .fwd_s4_load, .hold_lsu_req
    );

endmodule

`default_nettype wire

//--- test/wb_cases.svh
//------------------------------------------------
// Writeback stage test cases
// Instruction fields, memory response, delays
// and expected retire results per row
//------------------------------------------------
`ifndef WB_CASES_SVH
`define WB_CASES_SVH

localparam int NUM_CASES = 20;

typedef struct packed {
    wb_pkg::fu_t     fu;
    wb_pkg::wb_uop_t uop;
    logic [4:0]      rd;
    logic [31:0]     opr_a;
    logic [31:0]     opr_b;
    logic            trap;          // Trap flagged upstream
    logic [1:0]      size;
    logic [31:0]     rdata;         // Memory response data
    logic            rerr;          // Memory response error
    int              rsp_dly;       // Cycles before dmem_recv
    int              ack_dly;       // Cycles before cf_ack
    logic            exp_wen;
    logic [31:0]     exp_wdata;
    logic            exp_cf;        // Redirect expected
    logic [31:0]     exp_target;
    logic            exp_trap;
    wb_pkg::cause_t  exp_cause;
} case_t;

case_t cases [NUM_CASES];

task automatic fill_cases;
    // ALU and MUL rows retire without stall
    cases[0]  = '{4'h1, 5'h00, 5'd1, 32'h1234_5678, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 0,
                  1'b1, 32'h1234_5678, 1'b0, 32'h0, 1'b0, 6'd0};
    cases[1]  = '{4'h2, 5'h00, 5'd2, 32'hdead_beef, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 0,
                  1'b1, 32'hdead_beef, 1'b0, 32'h0, 1'b0, 6'd0};
    // Loads with strobe in opr_a and address in opr_b
    cases[2]  = '{4'h4, 5'h15, 5'd3, 32'h2, 32'h1001, 1'b0, 2'd2, 32'h4433_8211, 1'b0, 2, 0,
                  1'b1, 32'hffff_ff82, 1'b0, 32'h0, 1'b0, 6'd0};   // LB at 1
    cases[3]  = '{4'h4, 5'h05, 5'd4, 32'h8, 32'h1003, 1'b0, 2'd2, 32'h9a00_0000, 1'b0, 3, 0,
                  1'b1, 32'h0000_009a, 1'b0, 32'h0, 1'b0, 6'd0};   // LBU at 3
    cases[4]  = '{4'h4, 5'h19, 5'd5, 32'hc, 32'h2002, 1'b0, 2'd2, 32'h8001_1234, 1'b0, 1, 0,
                  1'b1, 32'hffff_8001, 1'b0, 32'h0, 1'b0, 6'd0};   // LH at 2
    cases[5]  = '{4'h4, 5'h09, 5'd6, 32'h3, 32'h2000, 1'b0, 2'd2, 32'h1234_f00d, 1'b0, 0, 0,
                  1'b1, 32'h0000_f00d, 1'b0, 32'h0, 1'b0, 6'd0};   // LHU at 0
    cases[6]  = '{4'h4, 5'h0d, 5'd7, 32'hf, 32'h3000, 1'b0, 2'd2, 32'hcafe_babe, 1'b0, 4, 0,
                  1'b1, 32'hcafe_babe, 1'b0, 32'h0, 1'b0, 6'd0};   // LW
    cases[7]  = '{4'h4, 5'h0e, 5'd0, 32'hf, 32'h3004, 1'b0, 2'd2, 32'h0, 1'b0, 2, 0,
                  1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 6'd0};           // SW
    // Branch and jumps where the link is PC plus twice size
    cases[8]  = '{4'h8, 5'h04, 5'd0, 32'h8000_0200, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 3,
                  1'b0, 32'h0, 1'b1, 32'h8000_0200, 1'b0, 6'd0};
    cases[9]  = '{4'h8, 5'h02, 5'd1, 32'h8000_0400, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 2,
                  1'b1, 32'h8000_0204, 1'b1, 32'h8000_0400, 1'b0, 6'd0};
    cases[10] = '{4'h8, 5'h03, 5'd5, 32'h8000_0800, 32'h0, 1'b0, 2'd1, 32'h0, 1'b0, 0, 0,
                  1'b1, 32'h8000_0402, 1'b1, 32'h8000_0800, 1'b0, 6'd0};
    // Traps to mtvec
    cases[11] = '{4'h8, 5'h09, 5'd0, 32'h0, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 1,
                  1'b0, 32'h0, 1'b1, 32'h0000_0100, 1'b1, 6'd3};   // Ebreak
    cases[12] = '{4'h8, 5'h0a, 5'd0, 32'h0, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 0,
                  1'b0, 32'h0, 1'b1, 32'h0000_0100, 1'b1, 6'd11};  // Ecall
    cases[13] = '{4'h1, 5'h00, 5'd7, 32'h2, 32'h0, 1'b1, 2'd2, 32'h0, 1'b0, 0, 2,
                  1'b0, 32'h0, 1'b1, 32'h0000_0100, 1'b1, 6'd2};   // Upstream trap
    cases[14] = '{4'h4, 5'h0d, 5'd8, 32'hf, 32'h3008, 1'b0, 2'd2, 32'h0, 1'b1, 2, 0,
                  1'b0, 32'h0, 1'b1, 32'h0000_0100, 1'b1, 6'd5};   // Load bus error
    cases[15] = '{4'h4, 5'h0e, 5'd0, 32'hf, 32'h300c, 1'b0, 2'd2, 32'h0, 1'b1, 1, 4,
                  1'b0, 32'h0, 1'b1, 32'h0000_0100, 1'b1, 6'd7};   // Store bus error
    cases[16] = '{4'h1, 5'h00, 5'd9, 32'h0bad_f00d, 32'h0, 1'b0, 2'd2, 32'h0, 1'b0, 0, 0,
                  1'b1, 32'h0bad_f00d, 1'b0, 32'h0, 1'b0, 6'd0};
    // Remaining byte offsets
    cases[17] = '{4'h4, 5'h15, 5'd10, 32'h1, 32'h4000, 1'b0, 2'd2, 32'h1122_33f0, 1'b0, 1, 0,
                  1'b1, 32'hffff_fff0, 1'b0, 32'h0, 1'b0, 6'd0};   // LB at 0
    cases[18] = '{4'h4, 5'h05, 5'd11, 32'h4, 32'h4002, 1'b0, 2'd2, 32'h5580_1234, 1'b0, 0, 0,
                  1'b1, 32'h0000_0080, 1'b0, 32'h0, 1'b0, 6'd0};   // LBU at 2
    cases[19] = '{4'h8, 5'h09, 5'd0, 32'h2, 32'h0, 1'b1, 2'd2, 32'h0, 1'b0, 0, 1,
                  1'b0, 32'h0, 1'b1, 32'h0000_0100, 1'b1, 6'd3};   // Ebreak beats upstream
endtask

`endif

//--- test/tb_wb_top.sv
//------------------------------------------------
// Writeback stage testbench
// Applies the case table with delayed memory
// and redirect responses, checks retire results
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_wb_top;

    localparam logic [31:0] PC_RESET = 32'h8000_0000;
    localparam logic [31:0] MTVEC    = 32'h0000_0100;
    localparam int          TIMEOUT  = 50;          // Cycles per wait

    logic g_clk, g_resetn, s4_trap, s4_valid, s4_busy, fwd_s4_load, gpr_wen;
    logic trap_cpu, cf_req, cf_ack, hold_lsu_req, dmem_recv, dmem_ack, dmem_error;
    logic [4:0]      s4_rd, fwd_s4_rd, gpr_rd;
    logic [1:0]      s4_size;
    logic [31:0]     s4_opr_a, s4_opr_b, fwd_s4_wdata, gpr_wdata, trap_pc;
    logic [31:0]     csr_mtvec, cf_target, dmem_rdata;
    wb_pkg::wb_uop_t s4_uop;
    wb_pkg::fu_t     s4_fu;
    wb_pkg::cause_t  trap_cause;

    int          seed;
    int          value_errors;
    int          timeout_errors;
    logic [31:0] model_pc;      // PC the stage should hold

    `include "wb_cases.svh"

    wb_top #(.PC_RESET(PC_RESET)) UUT (.*);

    always #10 g_clk = ~g_clk;

    //------------------------------------------------
    // Compare tasks
    task automatic check_word(input string name, input logic [wb_pkg::XLEN-1:0] got,
                              input logic [wb_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_cause(input string name, input wb_pkg::cause_t got,
                               input wb_pkg::cause_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    //------------------------------------------------
    // Apply one table row with inline responders
    task automatic run_case(input int idx);
        case_t c;
        int    rdly;
        int    count;
        logic  busy_exp;
        logic  done;
        logic  is_lsu;
        c      = cases[idx];
        is_lsu = c.fu[wb_pkg::FU_LSU];
        rdly   = c.rsp_dly + ($random(seed) & 3);  // Extra memory latency
        @(posedge g_clk);
        #1;
        s4_fu = c.fu;
        s4_uop = c.uop;
        s4_rd = c.rd;
        s4_opr_a = c.opr_a;
        s4_opr_b = c.opr_b;
        s4_trap = c.trap;
        s4_size = c.size;
        s4_valid = 1'b1;
        dmem_rdata = c.rdata;
        dmem_error = c.rerr;
        count = 0;
        done = 1'b0;
        while (!done && count < TIMEOUT) begin
            dmem_recv = is_lsu && (count >= rdly);  // Held low for the delay
            cf_ack    = (count >= c.ack_dly);
            @(negedge g_clk);                       // Outputs settled by mid cycle
            if (count == 0) check_word("trap_pc", trap_pc, model_pc);
            busy_exp = (is_lsu && count < rdly) || (c.exp_cf && count < c.ack_dly);
            check_bit("s4_busy", s4_busy, busy_exp);
            check_bit("gpr_wen", gpr_wen, !busy_exp && c.exp_wen); // Result cycle only
            check_bit("hold_lsu_req", hold_lsu_req, busy_exp || c.exp_cf);
            check_bit("dmem_ack", dmem_ack, is_lsu && count <= rdly);
            if (cf_req && c.exp_cf) check_word("cf_target", cf_target, c.exp_target);
            if (!s4_busy) begin
                check_bit("cf_req", cf_req, c.exp_cf);
                check_bit("trap_cpu", trap_cpu, c.exp_trap);
                if (c.exp_trap) check_cause("trap_cause", trap_cause, c.exp_cause);
                check_word("fwd_s4_rd", {27'd0, fwd_s4_rd}, {27'd0, c.rd});
                check_bit("fwd_s4_load", fwd_s4_load, is_lsu);
                if (c.exp_wen) begin
                    check_word("gpr_wdata", gpr_wdata, c.exp_wdata);
                    check_word("gpr_rd", {27'd0, gpr_rd}, {27'd0, c.rd});
                    check_word("fwd_s4_wdata", fwd_s4_wdata, c.exp_wdata);
                end
                done = 1'b1;
            end
            @(posedge g_clk);
            #1;
            count++;
        end
        // Idle cycle between rows
        s4_valid = 1'b0;
        s4_fu = '0;
        s4_uop = '0;
        s4_trap = 1'b0;
        dmem_recv = 1'b0;
        cf_ack = 1'b0;
        if (!done) begin
            $display("Timeout: row %0d did not retire within %0d cycles", idx, TIMEOUT);
            timeout_errors++;
        end else if (c.exp_cf) begin
            model_pc = c.exp_target;
        end else begin
            model_pc = model_pc + 2 * c.size;
        end
    endtask

    //------------------------------------------------
    // Main sequence
    initial begin
        seed = 13;
        value_errors = 0;
        timeout_errors = 0;
        g_clk = 1'b0;
        g_resetn = 1'b0;
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_uop = '0;
        s4_fu = '0;
        s4_trap = 1'b0;
        s4_size = '0;
        s4_valid = 1'b0;
        csr_mtvec = MTVEC;
        cf_ack = 1'b0;
        dmem_recv = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        model_pc = PC_RESET;
        fill_cases();
        repeat (5) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        @(negedge g_clk);
        check_bit("cf_req", cf_req, 1'b0);      // Quiet after reset
        check_bit("gpr_wen", gpr_wen, 1'b0);
        check_bit("dmem_ack", dmem_ack, 1'b0);
        for (int i = 0; i < NUM_CASES && timeout_errors == 0; i++) begin
            run_case(i);
        end
        @(negedge g_clk);
        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+test
source/wb_pkg.sv
source/wb_control_flow.sv
source/wb_load_unit.sv
source/wb_retire.sv
source/wb_top.sv
test/tb_wb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the writeback stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_wb_top -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
